/* include/pe_macros.svh */
`ifndef PE_MACROS_SVH
`define PE_MACROS_SVH

// --------------------
// datapath widths
// --------------------
// sample word, signed Q8.8
`define PE_DATA_W 16
`define PE_FRAC_W 8
// accumulator holds Q16.16 products
`define PE_ACC_W 32

// --------------------
// storage depths
// --------------------
`define PE_WGT_DEPTH 16
`define PE_IN_DEPTH 8
`define PE_OUT_DEPTH 4

// cycles from mac start to accumulator update
`define PE_MAC_LAT 2

`endif

/* logic/macUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module macUnit (
	input wire clk,
	input wire rstN,
	macIf.unit mac
);
	import peDataPkg::*;

	accT prod;
	logic prodValid;

	// --------------------
	// stage 1, product
	// --------------------
	// Q8.8 times Q8.8 lands as Q16.16
	always_ff @(posedge clk)
	begin
		if (mac.start)
			prod <= accT'(mac.opA) * accT'(mac.opB);
	end

	// --------------------
	// stage 2, accumulate
	// --------------------
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			prodValid <= 1'b0;
			mac.done <= 1'b0;
			mac.acc <= '0;
		end
		else
		begin
			prodValid <= mac.start;
			// done rises with the new sum
			mac.done <= prodValid;
			if (mac.clear)
				mac.acc <= '0;
			else if (prodValid)
				mac.acc <= mac.acc + prod;
		end
	end

endmodule

`default_nettype wire

/* logic/peCtrlPkg.sv */
`default_nettype none

package peCtrlPkg;

	// command opcodes
	typedef enum logic [2:0]
	{
		MA = 3'd0,
		MAB = 3'd1,
		BIAS = 3'd2,
		ACT = 3'd3,
		ACTCLR = 3'd4,
		LOAD = 3'd5,
		IDLE = 3'd6
	} peOpE;

	// sequencer states
	typedef enum logic [1:0]
	{
		READY,
		MACWAIT,
		ACTWAIT,
		PUSH
	} seqStateE;

endpackage

`default_nettype wire

/* logic/peDataPkg.sv */
`default_nettype none
`include "pe_macros.svh"

package peDataPkg;

	// signed fixed point sample
	typedef logic signed [`PE_DATA_W-1:0] sampleT;

	// accumulator wide enough for a full product
	typedef logic signed [`PE_ACC_W-1:0] accT;

	// pointer into the weight store
	typedef logic [$clog2(`PE_WGT_DEPTH)-1:0] wgtIdxT;

endpackage

`default_nettype wire

/* logic/peIfs.sv */
`timescale 1ns/1ps
`default_nettype none

// --------------------
// multiply-accumulate
// --------------------
interface macIf;
	import peDataPkg::*;

	logic start;
	logic clear;
	logic done;
	sampleT opA;
	sampleT opB;
	accT acc;

	modport seq (output start, clear, opA, opB, input done, acc);
	modport unit (input start, clear, opA, opB, output done, acc);
endinterface

// --------------------
// activation
// --------------------
interface actIf;
	import peDataPkg::*;

	logic start;
	logic done;
	accT x;
	sampleT y;

	modport seq (output start, x, input done, y);
	modport unit (input start, x, output done, y);
endinterface

// --------------------
// sample queue
// --------------------
interface fifoIf;
	import peDataPkg::*;

	logic push;
	logic pushReady;
	logic pop;
	logic flush;
	logic popValid;
	sampleT pushData;
	sampleT popData;

	modport queue (input push, pushData, pop, flush, output pushReady, popData, popValid);
	// write only side
	modport producer (output push, pushData, input pushReady);
	// read and write side, full test stays inside the queue
	modport user (output push, pushData, pop, flush, input popData, popValid);
endinterface

// weight store access
interface wgtIf;
	import peDataPkg::*;

	logic load;
	logic advance;
	sampleT loadData;
	sampleT weight;

	modport seq (output load, loadData, advance, input weight);
	modport store (input load, loadData, advance, output weight);
endinterface

`default_nettype wire

/* logic/peSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module peSequencer (
	input wire clk,
	input wire rstN,
	input wire cmdValid,
	input wire peCtrlPkg::peOpE cmdOp,
	input wire peDataPkg::sampleT cmdData,
	output logic cmdReady,
	macIf.seq mac,
	actIf.seq act,
	wgtIf.seq wgt,
	fifoIf.user inQ,
	fifoIf.producer outQ
);
	import peCtrlPkg::*;
	import peDataPkg::*;

	seqStateE state;
	seqStateE stateNext;
	sampleT bufHead;
	logic accept;
	logic macOp;
	logic actOp;
	logic pushDone;
	logic isClr;

	// --------------------
	// command decode
	// --------------------
	assign cmdReady = (state == READY);
	assign accept = cmdValid && cmdReady;
	assign macOp = accept && (cmdOp inside {MA, MAB, BIAS});
	assign actOp = accept && (cmdOp inside {ACT, ACTCLR});
	// result lands in the output queue this cycle
	assign pushDone = (state == PUSH) && outQ.pushReady;

	// mac operands, an empty buffer feeds zero
	assign bufHead = inQ.popValid ? inQ.popData : '0;
	assign mac.start = macOp;
	assign mac.opA = (cmdOp == MAB) ? bufHead : cmdData;
	assign mac.opB = wgt.weight;
	// sum is spent once its activation is queued
	assign mac.clear = pushDone;

	// weights, LOAD writes and every mac op steps the read side
	assign wgt.load = accept && (cmdOp == LOAD);
	assign wgt.loadData = cmdData;
	assign wgt.advance = macOp;

	// input buffer records MA and MAB words, BIAS leaves it alone
	assign inQ.pop = accept && (cmdOp == MAB) && inQ.popValid;
	assign inQ.flush = pushDone && isClr;
	assign inQ.push = (accept && (cmdOp inside {MA, MAB})) || inQ.flush;
	// after ACTCLR the buffer holds only the new result
	assign inQ.pushData = (state == PUSH) ? act.y : cmdData;

	// activation
	assign act.start = actOp;
	assign act.x = mac.acc;
	// held until the output queue has room
	assign outQ.push = (state == PUSH);
	assign outQ.pushData = act.y;

	// --------------------
	// state machine
	// --------------------
	always_comb
	begin
		stateNext = state;
		case (state)
			READY:
				if (macOp)
					stateNext = MACWAIT;
				else if (actOp)
					stateNext = ACTWAIT;
			MACWAIT:
				if (mac.done)
					stateNext = READY;
			ACTWAIT:
				if (act.done)
					stateNext = PUSH;
			PUSH:
				if (outQ.pushReady)
					stateNext = READY;
			default:
				stateNext = READY;
		endcase
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= READY;
			isClr <= 1'b0;
		end
		else
		begin
			state <= stateNext;
			// remember ACTCLR for the push cycle
			if (actOp)
				isClr <= (cmdOp == ACTCLR);
		end
	end

endmodule

`default_nettype wire

/* logic/peTop.sv */
`timescale 1ns/1ps
`default_nettype none
`include "pe_macros.svh"

module peTop (
	input wire clk,
	input wire rstN,
	input wire cmdValid,
	input wire peCtrlPkg::peOpE cmdOp,
	input wire peDataPkg::sampleT cmdData,
	output logic cmdReady,
	output logic outValid,
	output peDataPkg::sampleT outData,
	input wire outReady
);

	macIf mac();
	actIf act();
	wgtIf wgt();
	fifoIf inQ();
	fifoIf outQ();

	// --------------------
	// control
	// --------------------
	peSequencer seq (
		.clk(clk),
		.rstN(rstN),
		.cmdValid(cmdValid),
		.cmdOp(cmdOp),
		.cmdData(cmdData),
		.cmdReady(cmdReady),
		.mac(mac.seq),
		.act(act.seq),
		.wgt(wgt.seq),
		.inQ(inQ.user),
		.outQ(outQ.producer)
	);

	// --------------------
	// datapath and storage
	// --------------------
	macUnit macU (.clk(clk), .rstN(rstN), .mac(mac.unit));
	sigmoidUnit sigU (.clk(clk), .rstN(rstN), .act(act.unit));
	weightStore wgtS (.clk(clk), .rstN(rstN), .wgt(wgt.store));
	sampleFifo #(.DEPTH(`PE_IN_DEPTH)) inBuf (.clk(clk), .rstN(rstN), .q(inQ.queue));
	sampleFifo #(.DEPTH(`PE_OUT_DEPTH)) outBuf (.clk(clk), .rstN(rstN), .q(outQ.queue));

	// result port is the output queue's read side
	assign outQ.pop = outReady;
	assign outQ.flush = 1'b0;
	assign outValid = outQ.popValid;
	assign outData = outQ.popData;

endmodule

`default_nettype wire

/* logic/sampleFifo.sv */
`timescale 1ns/1ps
`default_nettype none
`include "pe_macros.svh"

module sampleFifo #(
	parameter int DEPTH = `PE_IN_DEPTH
) (
	input wire clk,
	input wire rstN,
	fifoIf.queue q
);
	import peDataPkg::*;

	localparam int PtrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	sampleT mem [DEPTH];
	logic [PtrW-1:0] wrPtr;
	logic [PtrW-1:0] rdPtr;
	logic [PtrW-1:0] wrNext;
	logic [PtrW-1:0] rdNext;
	logic full;
	logic empty;
	logic pushOk;
	logic popOk;

	// flush empties the queue first, so a push beside it always fits
	assign pushOk = q.push && (q.flush || !full);
	assign popOk = q.pop && !empty;
	assign wrNext = (wrPtr == PtrW'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
	assign rdNext = (rdPtr == PtrW'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;

	assign q.pushReady = !full;
	assign q.popValid = !empty;
	// head of queue
	assign q.popData = mem[rdPtr];

	always_ff @(posedge clk)
	begin
		if (pushOk)
			mem[wrPtr] <= q.pushData;
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			full <= 1'b0;
			empty <= 1'b1;
		end
		else if (q.flush)
		begin
			// drop everything by catching the read pointer up
			rdPtr <= wrPtr;
			full <= 1'b0;
			empty <= !pushOk;
			if (pushOk)
				wrPtr <= wrNext;
		end
		else
		begin
			if (pushOk)
				wrPtr <= wrNext;
			if (popOk)
				rdPtr <= rdNext;
			// flags move only when the count changes
			if (pushOk && !popOk)
			begin
				full <= (wrNext == rdPtr);
				empty <= 1'b0;
			end
			else if (popOk && !pushOk)
			begin
				empty <= (rdNext == wrPtr);
				full <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* logic/sigmoidUnit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "pe_macros.svh"

module sigmoidUnit (
	input wire clk,
	input wire rstN,
	actIf.unit act
);
	import peDataPkg::*;

	// one quotient bit per cycle
	localparam int Iter = `PE_DATA_W;
	localparam accT SatHi = (accT'(1) <<< (`PE_DATA_W - 1)) - accT'(1);
	localparam accT SatLo = -(accT'(1) <<< (`PE_DATA_W - 1));

	accT shifted;
	sampleT xSat;
	logic [`PE_DATA_W-1:0] mag;
	logic [`PE_DATA_W-1:0] divisor;
	logic [`PE_DATA_W-1:0] rem;
	logic [`PE_DATA_W-1:0] dvd;
	logic [`PE_DATA_W-1:0] quoNext;
	logic [`PE_DATA_W:0] shiftRem;
	logic [$clog2(Iter)-1:0] cnt;
	logic qBit;
	logic busy;
	logic neg;
	logic lastStep;

	// --------------------
	// operand prep
	// --------------------
	always_comb
	begin
		// drop the extra fraction bits of the product sum
		shifted = act.x >>> `PE_FRAC_W;
		if (shifted > SatHi)
			xSat = sampleT'(SatHi);
		else if (shifted < SatLo)
			xSat = sampleT'(SatLo);
		else
			xSat = sampleT'(shifted);
		// -32768 still reads right as unsigned
		mag = xSat[`PE_DATA_W-1] ? -xSat : xSat;
	end

	// restoring step, remainder always below the divisor
	assign shiftRem = {rem, dvd[`PE_DATA_W-1]};
	assign qBit = (shiftRem >= {1'b0, divisor});
	// dividend bits leave the top of dvd while quotient bits enter below
	assign quoNext = {dvd[`PE_DATA_W-2:0], qBit};
	assign lastStep = (cnt == ($clog2(Iter))'(Iter - 1));

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			busy <= 1'b0;
			cnt <= '0;
			act.done <= 1'b0;
		end
		else
		begin
			act.done <= busy && lastStep;
			if (act.start)
			begin
				busy <= 1'b1;
				cnt <= '0;
			end
			else if (busy)
			begin
				cnt <= cnt + 1'b1;
				if (lastStep)
					busy <= 1'b0;
			end
		end
	end

	// --------------------
	// divider datapath
	// --------------------
	// |x| << 8 over 256 + |x|
	always_ff @(posedge clk)
	begin
		if (act.start)
		begin
			neg <= xSat[`PE_DATA_W-1];
			divisor <= mag + `PE_DATA_W'(1 << `PE_FRAC_W);
			// top part of the widened dividend preloads the remainder
			rem <= mag >> (`PE_DATA_W - `PE_FRAC_W);
			dvd <= mag << `PE_FRAC_W;
		end
		else if (busy)
		begin
			rem <= qBit ? `PE_DATA_W'(shiftRem - {1'b0, divisor}) : shiftRem[`PE_DATA_W-1:0];
			dvd <= quoNext;
			// magnitude truncated, so sign restore rounds toward zero
			if (lastStep)
				act.y <= neg ? -sampleT'(quoNext) : sampleT'(quoNext);
		end
	end

endmodule

`default_nettype wire

/* logic/weightStore.sv */
`timescale 1ns/1ps
`default_nettype none
`include "pe_macros.svh"

module weightStore (
	input wire clk,
	input wire rstN,
	wgtIf.store wgt
);
	import peDataPkg::*;

	sampleT mem [`PE_WGT_DEPTH];
	wgtIdxT wrPtr;
	wgtIdxT rdPtr;
	wgtIdxT wrNext;
	wgtIdxT rdNext;
	logic full;
	logic doLoad;

	// a load into a full store is dropped
	assign doLoad = wgt.load && !full;
	assign wrNext = (wrPtr == wgtIdxT'(`PE_WGT_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
	assign rdNext = (rdPtr == wgtIdxT'(`PE_WGT_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
	// current weight, read without a wait state
	assign wgt.weight = mem[rdPtr];

	always_ff @(posedge clk)
	begin
		if (doLoad)
			mem[wrPtr] <= wgt.loadData;
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			full <= 1'b0;
		end
		else
		begin
			if (doLoad)
				wrPtr <= wrNext;
			// each weight read frees its slot
			if (wgt.advance)
			begin
				rdPtr <= rdNext;
				full <= 1'b0;
			end
			else if (doLoad && (wrNext == rdPtr))
				full <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build the peTb simulation with Verilator, run it, and judge the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module peTb -o peSim \
	|| { echo "build failed"; exit 1; }
./obj_dir/peSim > sim.log 2>&1 || echo "simulator returned an error status" >> sim.log
cat sim.log
grep -q "Simulation completed successfully" sim.log \
	&& ! grep -q "Simulation failed" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }

/* tb.f */
+incdir+include
logic/peCtrlPkg.sv
logic/peDataPkg.sv
logic/peIfs.sv
logic/weightStore.sv
logic/sampleFifo.sv
logic/macUnit.sv
logic/sigmoidUnit.sv
logic/peSequencer.sv
logic/peTop.sv
verif/pe_chk.sv
verif/peTb.sv

/* verif/peTb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "pe_macros.svh"

module peTb;
	import peCtrlPkg::*;
	import peDataPkg::*;

	localparam int ClkPeriod = 8;
	// an ACT needs about 19 cycles, so a longer wait means the output queue is full
	localparam int StallCycles = 30;

	// one stimulus row where hold keeps outReady low
	typedef struct packed
	{
		peOpE op;
		sampleT data;
		logic hold;
	} rowT;

	logic clk = 1'b0;
	logic rstN = 1'b1;
	logic cmdValid;
	peOpE cmdOp;
	sampleT cmdData;
	logic cmdReady;
	logic outValid;
	sampleT outData;
	logic outReady;

	rowT tbl [$];
	logic tblReady = 1'b0;
	logic holdLow = 1'b0;
	integer seed = 32'h4338_403c;
	logic [31:0] rnd;
	int checks = 0;
	int errors = 0;
	int outCount = 0;
	int stallSeen = 0;

	// --------------------
	// reference model state
	// --------------------
	sampleT wgtModel [`PE_WGT_DEPTH];
	int wgtWr = 0;
	int wgtRd = 0;
	logic wgtFull = 1'b0;
	sampleT inModel [$];
	sampleT expQ [$];
	accT accModel = '0;

	peTop dut (
		.clk(clk),
		.rstN(rstN),
		.cmdValid(cmdValid),
		.cmdOp(cmdOp),
		.cmdData(cmdData),
		.cmdReady(cmdReady),
		.outValid(outValid),
		.outData(outData),
		.outReady(outReady)
	);

	bind peTop peChk chk (
		.clk(clk),
		.rstN(rstN),
		.cmdValid(cmdValid),
		.cmdReady(cmdReady),
		.cmdOp(cmdOp),
		.outValid(outValid),
		.outReady(outReady),
		.outData(outData)
	);

	always #(ClkPeriod / 2) clk = ~clk;

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("error %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// x/(1+|x|) taken on the Q8.8 value of the sum and returned in Q8.8
	function automatic sampleT expectedSigmoid(input accT acc);
		longint x;
		longint mag;
		longint q;
		x = acc >>> `PE_FRAC_W;
		// clamp to the sample range
		if (x > 32767)
			x = 32767;
		else if (x < -32768)
			x = -32768;
		mag = (x < 0) ? -x : x;
		// magnitude divide truncates and the sign goes back on afterwards
		q = (mag << `PE_FRAC_W) / (mag + (1 << `PE_FRAC_W));
		return sampleT'((x < 0) ? -q : q);
	endfunction

	// product with the current weight before the weight pointer steps
	task automatic accumulate(input sampleT a);
		accModel = accModel + accT'(a) * accT'(wgtModel[wgtRd]);
		wgtRd = (wgtRd + 1) % `PE_WGT_DEPTH;
		wgtFull = 1'b0;
	endtask

	// effect of one accepted command
	task automatic updateModel(input peOpE op, input sampleT d);
		sampleT head;
		sampleT y;
		logic room;
		case (op)
			LOAD:
				// a full store drops the weight
				if (!wgtFull)
				begin
					wgtModel[wgtWr] = d;
					wgtWr = (wgtWr + 1) % `PE_WGT_DEPTH;
					wgtFull = (wgtWr == wgtRd);
				end
			MA:
			begin
				accumulate(d);
				if (inModel.size() < `PE_IN_DEPTH)
					inModel.push_back(d);
			end
			MAB:
			begin
				// room is judged before the pop of the same command
				room = (inModel.size() < `PE_IN_DEPTH);
				head = '0;
				if (inModel.size() > 0)
					head = inModel.pop_front();
				accumulate(head);
				if (room)
					inModel.push_back(d);
			end
			BIAS:
				accumulate(d);
			ACT, ACTCLR:
			begin
				y = expectedSigmoid(accModel);
				expQ.push_back(y);
				accModel = '0;
				// next layer starts from this result alone
				if (op == ACTCLR)
				begin
					inModel.delete();
					inModel.push_back(y);
				end
			end
			default:
				;
		endcase
	endtask

	task automatic addRow(input peOpE op, input sampleT data, input logic hold);
		rowT r;
		r.op = op;
		r.data = data;
		r.hold = hold;
		tbl.push_back(r);
	endtask

	// --------------------
	// stimulus table
	// --------------------
	task automatic buildTable();
		int k;
		// weights run from negative to positive
		for (k = 0; k < `PE_WGT_DEPTH; k++)
			addRow(LOAD, sampleT'(k * 53 - 300), 1'b0);
		// store is full so this one is dropped
		addRow(LOAD, 16'sh7777, 1'b0);
		addRow(IDLE, '0, 1'b0);
		// empty buffer feeds zero
		addRow(MAB, 16'sh0300, 1'b0);
		addRow(MA, 16'sh0100, 1'b0);
		addRow(MA, 16'sh0080, 1'b0);
		addRow(MA, 16'shff80, 1'b0);
		addRow(MA, 16'sh0200, 1'b0);
		addRow(ACT, '0, 1'b0);
		// replay of the recorded samples
		addRow(MAB, 16'sh0040, 1'b0);
		addRow(MAB, 16'shffc0, 1'b0);
		addRow(MAB, 16'sh0020, 1'b0);
		addRow(MAB, 16'sh0180, 1'b0);
		addRow(MAB, 16'sh0010, 1'b0);
		addRow(ACT, '0, 1'b0);
		// bias leaves the buffer alone
		addRow(BIAS, 16'sh0100, 1'b0);
		addRow(MAB, 16'sh0050, 1'b0);
		addRow(ACT, '0, 1'b0);
		// ACTCLR result becomes the only buffered sample
		addRow(MA, 16'sh0400, 1'b0);
		addRow(ACTCLR, '0, 1'b0);
		addRow(MAB, '0, 1'b0);
		addRow(ACT, '0, 1'b0);
		// saturation to positive then negative
		for (k = 0; k < 3; k++)
			addRow(MA, 16'sh7fff, 1'b0);
		addRow(ACT, '0, 1'b0);
		for (k = 0; k < 3; k++)
			addRow(MA, 16'sh7fff, 1'b0);
		addRow(ACT, '0, 1'b0);
		// five results against a four deep output queue
		for (k = 1; k <= 5; k++)
		begin
			addRow(MA, sampleT'(k * 256), 1'b1);
			addRow(ACT, '0, 1'b1);
		end
		addRow(MA, 16'sh0600, 1'b0);
		addRow(ACT, '0, 1'b0);
	endtask

	// --------------------
	// result side
	// --------------------
	initial
	begin
		outReady = 1'b0;
		forever
		begin
			@(negedge clk);
			rnd = $random(seed);
			outReady = holdLow ? 1'b0 : (rnd[1:0] != 2'b00);
			// both high now means a transfer at the next rising edge
			if (rstN && outValid && outReady)
			begin
				if (expQ.size() == 0)
				begin
					errors++;
					$display("error: outData %h arrived with no result expected", outData);
				end
				else
					check("outData", outData, expQ.pop_front());
				outCount++;
			end
		end
	end

	initial
	begin
		wait (tblReady);
		#(tbl.size() * 40 * ClkPeriod);
		$display("timeout: run did not finish within %0d ns, %0d errors so far",
			tbl.size() * 40 * ClkPeriod, errors);
		$display("Simulation failed");
		$finish;
	end

	// --------------------
	// command side
	// --------------------
	initial
	begin
		int i;
		int waited;
		int stallOut;
		logic released;
		cmdValid = 1'b0;
		cmdOp = IDLE;
		cmdData = '0;
		rstN = 1'b0;
		released = 1'b0;
		stallOut = 0;
		buildTable();
		tblReady = 1'b1;
		repeat (2) @(negedge clk);
		rstN = 1'b1;
		@(negedge clk);
		check("cmdReady", cmdReady, 1);
		check("outValid", outValid, 0);
		for (i = 0; i < tbl.size(); i++)
		begin
			// hold changes on a rising edge so the result side sees it cleanly
			if (tbl[i].hold != holdLow)
			begin
				if (tbl[i].hold)
				begin
					while (outValid)
						@(negedge clk);
				end
				@(posedge clk);
				holdLow = tbl[i].hold;
				@(negedge clk);
			end
			while (!cmdReady)
				@(negedge clk);
			cmdOp = tbl[i].op;
			cmdData = tbl[i].data;
			cmdValid = 1'b1;
			// taken at the next rising edge
			updateModel(tbl[i].op, tbl[i].data);
			@(negedge clk);
			cmdValid = 1'b0;
			waited = 0;
			while (!cmdReady)
			begin
				if (holdLow && waited == StallCycles)
				begin
					// output queue is full and the sequencer waits in PUSH
					check("outValid", outValid, 1);
					stallSeen++;
					stallOut = outCount;
					released = 1'b1;
					@(posedge clk);
					holdLow = 1'b0;
				end
				@(negedge clk);
				waited++;
			end
			// cmdReady may only return once a result has left the queue
			if (released)
			begin
				check("outCount grew", (outCount > stallOut) ? 1 : 0, 1);
				released = 1'b0;
			end
		end
		if (holdLow)
		begin
			@(posedge clk);
			holdLow = 1'b0;
		end
		while (expQ.size() != 0)
			@(negedge clk);
		repeat (4) @(negedge clk);
		check("outValid", outValid, 0);
		check("stallSeen", stallSeen, 1);
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* verif/pe_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module peChk (
	input wire clk,
	input wire rstN,
	input wire cmdValid,
	input wire cmdReady,
	input wire peCtrlPkg::peOpE cmdOp,
	input wire outValid,
	input wire outReady,
	input wire peDataPkg::sampleT outData
);
	import peCtrlPkg::*;

	// --------------------
	// result port
	// --------------------
	// queue head must not move while the consumer stalls
	outDataHeld: assert property (@(posedge clk) disable iff (!rstN)
		(outValid && !outReady) |=> $stable(outData))
		else $error("outData changed while a result was waiting");

	// queues are empty while reset is held
	outQuietInReset: assert property (@(posedge clk) !rstN |-> !outValid)
		else $error("outValid high during reset");

	// --------------------
	// command port
	// --------------------
	// a multiply-add always leaves READY on the next edge
	maBlocksCmd: assert property (@(posedge clk) disable iff (!rstN)
		(cmdValid && cmdReady && cmdOp == MA) |=> !cmdReady)
		else $error("cmdReady stayed high after an MA command");

endmodule

`default_nettype wire
